//--- Bender.yml
package:
  name: mmu

sources:
  - include_dirs:
      - common
    files:
      - common/mmu_pkg.sv
      - hdl/mmu_walk_ctrl.sv
      - tlb/mmu_tlb.sv
      - hdl/mmu_mem_mux.sv
      - hdl/mmu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/mmu_tb.sv

//--- common/mmu_defines.svh
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// Core side address width
`define MMU_ADDR_W 32

// Store data width towards memory
`define MMU_DATA_W 32

// Read data width from memory with one table entry per beat
`define MMU_MEM_RDATA_W 64

// Address space id width
`define MMU_ASID_W 14

// In-page offset width of 4 KiB pages
`define MMU_PAGE_SHIFT 12

// TLB depth
`define MMU_TLB_ENTRIES 4

// Log2 of table entry size in bytes
`define MMU_ENTRY_SHIFT 3

// Flag bits held in the low part of an entry
`define MMU_FLAGS_W 12

`endif

//--- common/mmu_pkg.sv
`include "mmu_defines.svh"

package mmu_pkg;

	// Address and data vectors
	typedef logic [`MMU_ADDR_W-1:0] vaddr_t;
	typedef logic [`MMU_ADDR_W-1:0] paddr_t;
	typedef logic [`MMU_ASID_W-1:0] asid_t;
	typedef logic [`MMU_DATA_W-1:0] word_t;
	typedef logic [`MMU_MEM_RDATA_W-1:0] mem_rdata_t;

	// Page number and frame share the upper address bits
	typedef logic [`MMU_ADDR_W-`MMU_PAGE_SHIFT-1:0] vpn_t;
	typedef logic [`MMU_ADDR_W-`MMU_PAGE_SHIFT-1:0] frame_t;
	typedef logic [`MMU_FLAGS_W-1:0] mmu_flags_t;

	// Access size and byte enables
	typedef logic [1:0] order_t;
	typedef logic [3:0] mask_t;

	// Paging mode from the core
	typedef enum logic [1:0] {
		PAGING_OFF = 2'd0,
		PAGING_L1 = 2'd1,
		PAGING_L2 = 2'd2
	} paging_mode_e;

	// Walk FSM
	typedef enum logic [2:0] {
		WALK_IDLE,
		WALK_T1_REQ,
		WALK_T1_WAIT,
		WALK_T2_REQ,
		WALK_T2_WAIT,
		WALK_ACCESS
	} walk_state_e;

	// Request from the core
	typedef struct packed {
		paging_mode_e mode;
		asid_t asid;
		paddr_t pdt;
		order_t order;
		mask_t mask;
		logic rw;
		vaddr_t addr;
		word_t data;
	} logic_req_t;

	// Command on the memory port
	typedef struct packed {
		logic req;
		logic mmu_use;
		order_t order;
		mask_t mask;
		logic rw;
		paddr_t addr;
		word_t data;
	} mem_cmd_t;

endpackage

//--- dv/mmu_tb.sv
`timescale 1ns/1ns
`include "mmu_defines.svh"

module mmu_tb;

	// One trace line holding a flush or a request with its expectations
	typedef struct packed {
		logic flush;
		mmu_pkg::logic_req_t req;
		logic [1:0] ntab;
		mmu_pkg::paddr_t tab0;
		mmu_pkg::paddr_t tab1;
		mmu_pkg::paddr_t final_addr;
		mmu_pkg::mmu_flags_t flags;
	} trace_op_t;

	logic iCLOCK;
	logic inRESET;
	logic iTLB_FLUSH;
	logic iLOGIC_REQ;
	mmu_pkg::logic_req_t iLOGIC;
	logic iMEMORY_LOCK;
	logic iMEMORY_VALID;
	mmu_pkg::mem_rdata_t iMEMORY_DATA;
	logic oLOGIC_LOCK;
	mmu_pkg::mem_cmd_t oMEMORY;
	logic oMMUFLAGS_REQ;
	mmu_pkg::mmu_flags_t oMMUFLAGS_FLAGS;

	// Trace contents and sparse table memory
	trace_op_t ops [$];
	mmu_pkg::mem_rdata_t mem_model [mmu_pkg::paddr_t];
	int num_req = 0;

	// Expectations of the open request
	mmu_pkg::paddr_t tab_q [$];
	mmu_pkg::mem_cmd_t exp_access;
	mmu_pkg::mmu_flags_t exp_flags;
	logic exp_strobe = 1'b0;
	logic exp_walk = 1'b0;
	logic active = 1'b0;
	logic done = 1'b0;

	// Lock hold tracking and pending table response
	logic held = 1'b0;
	mmu_pkg::mem_cmd_t held_cmd;
	int rsp_wait = 0;
	mmu_pkg::mem_rdata_t rsp_data;

	int err_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	mmu_top mmu_top_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iTLB_FLUSH(iTLB_FLUSH),
		.iLOGIC_REQ(iLOGIC_REQ),
		.iLOGIC(iLOGIC),
		.iMEMORY_LOCK(iMEMORY_LOCK),
		.iMEMORY_VALID(iMEMORY_VALID),
		.iMEMORY_DATA(iMEMORY_DATA),
		.oLOGIC_LOCK(oLOGIC_LOCK),
		.oMEMORY(oMEMORY),
		.oMMUFLAGS_REQ(oMMUFLAGS_REQ),
		.oMMUFLAGS_FLAGS(oMMUFLAGS_FLAGS)
	);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_cmd(input string name, input mmu_pkg::mem_cmd_t got,
		input mmu_pkg::mem_cmd_t exp);
		if (got !== exp) begin
			err_count++;
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_flags(input string name, input mmu_pkg::mmu_flags_t got,
		input mmu_pkg::mmu_flags_t exp);
		if (got !== exp) begin
			err_count++;
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_strobe(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_count++;
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
		end
	endtask

	// 8-byte table read from the walk
	function automatic mmu_pkg::mem_cmd_t table_cmd(input mmu_pkg::paddr_t addr);
		mmu_pkg::mem_cmd_t c;
		c = '0;
		c.req = 1'b1;
		c.mmu_use = 1'b1;
		c.order = 2'd2;
		c.addr = addr;
		return c;
	endfunction

	// Final access keeps the core's fields and moves only the address
	function automatic mmu_pkg::mem_cmd_t access_cmd(input mmu_pkg::logic_req_t r,
		input mmu_pkg::paddr_t addr);
		mmu_pkg::mem_cmd_t c;
		c.req = 1'b1;
		c.mmu_use = 1'b0;
		c.order = r.order;
		c.mask = r.mask;
		c.rw = r.rw;
		c.addr = addr;
		c.data = r.data;
		return c;
	endfunction

	task automatic load_trace();
		int fd;
		int code;
		logic [63:0] tok;
		logic [8*160-1:0] line;
		logic [63:0] col [0:12];
		trace_op_t op;
		fd = $fopen("dv/mmu_trace.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the trace file dv/mmu_trace.txt");
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			op = '0;
			if (tok == "#") begin
				code = $fgets(line, fd);
			end else if (tok == "E") begin
				code = $fscanf(fd, "%h %h", col[0], col[1]);
				mem_model[col[0][31:0]] = col[1];
			end else if (tok == "F") begin
				op.flush = 1'b1;
				ops.push_back(op);
			end else if (tok == "R") begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
					col[0], col[1], col[2], col[3], col[4], col[5], col[6],
					col[7], col[8], col[9], col[10], col[11], col[12]);
				op.req.mode = mmu_pkg::paging_mode_e'(col[0][1:0]);
				op.req.asid = col[1][`MMU_ASID_W-1:0];
				op.req.pdt = col[2][31:0];
				op.req.order = col[3][1:0];
				op.req.mask = col[4][3:0];
				op.req.rw = col[5][0];
				op.req.addr = col[6][31:0];
				op.req.data = col[7][31:0];
				op.ntab = col[8][1:0];
				op.tab0 = col[9][31:0];
				op.tab1 = col[10][31:0];
				op.final_addr = col[11][31:0];
				op.flags = col[12][11:0];
				ops.push_back(op);
				num_req++;
			end else begin
				abort_run("the trace holds a line of unknown kind");
			end
		end
		$fclose(fd);
	endtask

	task automatic run_op(input trace_op_t op);
		@(posedge iCLOCK);
		#1;
		if (op.flush) begin
			iTLB_FLUSH = 1'b1;
			@(posedge iCLOCK);
			#1;
			iTLB_FLUSH = 1'b0;
		end else begin
			// Expected table reads in walk order
			tab_q.delete();
			if (op.ntab > 0) begin
				tab_q.push_back(op.tab0);
			end
			if (op.ntab > 1) begin
				tab_q.push_back(op.tab1);
			end
			exp_access = access_cmd(op.req, op.final_addr);
			exp_flags = op.flags;
			exp_strobe = op.req.mode != mmu_pkg::PAGING_OFF;
			exp_walk = op.ntab != 0;
			done = 1'b0;
			iLOGIC = op.req;
			iLOGIC_REQ = 1'b1;
			// Hold the strobe until an edge with the lock low
			@(negedge iCLOCK);
			while (oLOGIC_LOCK) begin
				@(negedge iCLOCK);
			end
			@(posedge iCLOCK);
			#1;
			iLOGIC_REQ = 1'b0;
			active = 1'b1;
			while (!done) begin
				@(posedge iCLOCK);
			end
		end
	endtask

	// 10 ns clock
	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;
	end

	// Random lock and table responses 1 ns after the edge
	initial begin
		iMEMORY_LOCK = 1'b0;
		iMEMORY_VALID = 1'b0;
		iMEMORY_DATA = '0;
		forever begin
			@(posedge iCLOCK);
			#1;
			iMEMORY_LOCK = ($urandom % 4) == 0;
			iMEMORY_VALID = 1'b0;
			if (rsp_wait > 0) begin
				rsp_wait--;
				if (rsp_wait == 0) begin
					iMEMORY_VALID = 1'b1;
					iMEMORY_DATA = rsp_data;
				end
			end
		end
	end

	// Port watch in mid cycle where inputs and outputs are settled
	always @(negedge iCLOCK) begin
		if (inRESET) begin
			// Core lock stays up through a walk and while an idle command is held
			check_strobe("oLOGIC_LOCK", oLOGIC_LOCK, active && (exp_walk || iMEMORY_LOCK));
			if (held) begin
				check_cmd("oMEMORY held under lock", oMEMORY, held_cmd);
			end
			if (oMEMORY.req) begin
				if (!active) begin
					abort_run("a memory command came up with no request outstanding");
				end
				if (oMEMORY.mmu_use) begin
					if (tab_q.size() == 0) begin
						abort_run("a table read came up that the trace does not expect");
					end
					check_cmd("oMEMORY", oMEMORY, table_cmd(tab_q[0]));
					check_strobe("oMMUFLAGS_REQ", oMMUFLAGS_REQ, 1'b0);
					if (!iMEMORY_LOCK) begin
						if (!mem_model.exists(oMEMORY.addr)) begin
							abort_run("a table read went to an address with no entry");
						end
						// Response 1 to 4 cycles later
						rsp_data = mem_model[oMEMORY.addr];
						rsp_wait = 1 + ($urandom % 4);
						void'(tab_q.pop_front());
					end
				end else begin
					if (tab_q.size() != 0) begin
						abort_run("the access came before all table reads were made");
					end
					check_cmd("oMEMORY", oMEMORY, exp_access);
					check_strobe("oMMUFLAGS_REQ", oMMUFLAGS_REQ, exp_strobe);
					if (exp_strobe) begin
						check_flags("oMMUFLAGS_FLAGS", oMMUFLAGS_FLAGS, exp_flags);
					end
					if (!iMEMORY_LOCK) begin
						active = 1'b0;
						done = 1'b1;
					end
				end
			end else begin
				check_strobe("oMMUFLAGS_REQ", oMMUFLAGS_REQ, 1'b0);
			end
			held = oMEMORY.req && iMEMORY_LOCK;
			held_cmd = oMEMORY;
		end
	end

	// Cycle limit from the trace length
	initial begin
		forever begin
			@(posedge iCLOCK);
			cycle_count++;
			if (cycle_limit > 0 && cycle_count > cycle_limit) begin
				abort_run($sformatf("timed out after %0d cycles waiting for a request",
					cycle_count));
			end
		end
	end

	initial begin
		void'($urandom(32'haaa5));
		inRESET = 1'b0;
		iTLB_FLUSH = 1'b0;
		iLOGIC_REQ = 1'b0;
		iLOGIC = '0;
		load_trace();
		cycle_limit = 200 * num_req + 16;
		repeat (8) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		foreach (ops[i]) begin
			run_op(ops[i]);
		end
		repeat (4) @(posedge iCLOCK);
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- dv/mmu_trace.txt
# E lines give a table entry address and its 64-bit word, F lines flush the TLB
# R mode asid pdt order mask rw addr data ntab tab0 tab1 final flags, all hex
E 00012018 00000000801230a7
E 00012020 000000007fff0055
E 00020240 0000000000030001
E 00031a28 00000000abcde3c5
R 0 0001 00010000 2 f 0 12345678 deadbeef 0 0 0 12345678 000
R 1 0001 00010000 2 f 0 00403abc 00000000 1 00012018 0 80123abc 0a7
R 1 0001 00010000 2 f 1 00403004 cafef00d 0 0 0 80123004 0a7
R 2 0005 00020000 2 f 0 12345678 00000000 2 00020240 00031a28 abcde678 3c5
R 2 0005 00020000 1 3 1 12345010 0000beef 0 0 0 abcde010 3c5
R 1 0002 00010000 2 f 0 00403abc 00000000 1 00012018 0 80123abc 0a7
R 1 0002 00010000 0 1 1 00403ffc 000000aa 0 0 0 80123ffc 0a7
F
R 1 0001 00010000 2 f 0 00403abc 00000000 1 00012018 0 80123abc 0a7
R 2 0005 00020000 2 f 0 12345678 00000000 2 00020240 00031a28 abcde678 3c5
R 1 0001 00010000 2 f 1 00404100 11223344 1 00012020 0 7fff0100 055
R 1 0001 00010000 2 f 0 00404800 00000000 0 0 0 7fff0800 055
R 0 0003 00000000 2 f 1 00000040 a5a5a5a5 0 0 0 00000040 000
R 2 0005 00020000 2 f 0 12345ffc 00000000 0 0 0 abcdeffc 3c5
R 1 0001 00010000 2 f 0 00403100 00000000 0 0 0 80123100 0a7

//--- files.f
+incdir+common
common/mmu_pkg.sv
hdl/mmu_walk_ctrl.sv
tlb/mmu_tlb.sv
hdl/mmu_mem_mux.sv
hdl/mmu_top.sv
dv/mmu_tb.sv

//--- hdl/mmu_mem_mux.sv
`timescale 1ns/1ns
`include "mmu_defines.svh"

module mmu_mem_mux (
	input logic req_valid,
	input mmu_pkg::logic_req_t req,
	input mmu_pkg::walk_state_e state,
	input logic iMEMORY_LOCK,
	input logic tlb_valid,
	input logic tlb_hit,
	input mmu_pkg::frame_t tlb_frame,
	input mmu_pkg::mmu_flags_t tlb_flags,
	input mmu_pkg::paddr_t table_addr,
	input mmu_pkg::frame_t entry_frame,
	input mmu_pkg::mmu_flags_t entry_flags,
	output mmu_pkg::mem_cmd_t oMEMORY,
	output logic oMMUFLAGS_REQ,
	output mmu_pkg::mmu_flags_t oMMUFLAGS_FLAGS
);

	logic idle_hit;
	logic translated;

	assign idle_hit = state == mmu_pkg::WALK_IDLE && req_valid && tlb_valid && tlb_hit;

	always_comb begin
		// Access fields of the latched request by default
		oMEMORY.req = 1'b0;
		oMEMORY.mmu_use = 1'b0;
		oMEMORY.order = req.order;
		oMEMORY.mask = req.mask;
		oMEMORY.rw = req.rw;
		oMEMORY.addr = req.addr;
		oMEMORY.data = req.data;
		if (req.mode == mmu_pkg::PAGING_OFF) begin
			oMEMORY.req = req_valid;
		end else begin
			case (state)
				mmu_pkg::WALK_IDLE: begin
					oMEMORY.req = idle_hit;
					oMEMORY.addr = {tlb_frame, req.addr[`MMU_PAGE_SHIFT-1:0]};
				end
				mmu_pkg::WALK_ACCESS: begin
					oMEMORY.req = 1'b1;
					oMEMORY.addr = {entry_frame, req.addr[`MMU_PAGE_SHIFT-1:0]};
				end
				default: begin
					// 8-byte table read raised only in request states
					oMEMORY.req = state == mmu_pkg::WALK_T1_REQ ||
						state == mmu_pkg::WALK_T2_REQ;
					oMEMORY.mmu_use = 1'b1;
					oMEMORY.order = 2'd2;
					oMEMORY.mask = '0;
					oMEMORY.rw = 1'b0;
					oMEMORY.addr = table_addr;
					oMEMORY.data = '0;
				end
			endcase
		end
	end

	// Flags go out with every translated access
	assign translated = req.mode != mmu_pkg::PAGING_OFF &&
		(idle_hit || state == mmu_pkg::WALK_ACCESS);
	assign oMMUFLAGS_REQ = translated;
	assign oMMUFLAGS_FLAGS = state == mmu_pkg::WALK_IDLE ? tlb_flags : entry_flags;

	// Lock must be driven whenever a command is offered
	always_comb begin
		a_lock_known: assert final (!oMEMORY.req || !$isunknown(iMEMORY_LOCK))
			else $error("memory lock unknown while a command is up");
	end

endmodule

//--- hdl/mmu_top.sv
`timescale 1ns/1ns
`include "mmu_defines.svh"

module mmu_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic iTLB_FLUSH,
	input logic iLOGIC_REQ,
	input mmu_pkg::logic_req_t iLOGIC,
	input logic iMEMORY_LOCK,
	input logic iMEMORY_VALID,
	input mmu_pkg::mem_rdata_t iMEMORY_DATA,
	output logic oLOGIC_LOCK,
	output mmu_pkg::mem_cmd_t oMEMORY,
	output logic oMMUFLAGS_REQ,
	output mmu_pkg::mmu_flags_t oMMUFLAGS_FLAGS
);

	// Latched request and walk progress
	logic req_valid;
	mmu_pkg::logic_req_t req;
	mmu_pkg::walk_state_e state;
	mmu_pkg::paddr_t table_addr;
	mmu_pkg::frame_t entry_frame;
	mmu_pkg::mmu_flags_t entry_flags;

	// TLB lookup and fill
	logic lookup;
	logic tlb_wr;
	mmu_pkg::frame_t tlb_wr_frame;
	mmu_pkg::mmu_flags_t tlb_wr_flags;
	logic tlb_valid;
	logic tlb_hit;
	mmu_pkg::frame_t tlb_frame;
	mmu_pkg::mmu_flags_t tlb_flags;

	mmu_walk_ctrl walk_ctrl_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iLOGIC_REQ(iLOGIC_REQ),
		.iLOGIC(iLOGIC),
		.iMEMORY_LOCK(iMEMORY_LOCK),
		.iMEMORY_VALID(iMEMORY_VALID),
		.iMEMORY_DATA(iMEMORY_DATA),
		.tlb_valid(tlb_valid),
		.tlb_hit(tlb_hit),
		.oLOGIC_LOCK(oLOGIC_LOCK),
		.req_valid(req_valid),
		.req(req),
		.state(state),
		.table_addr(table_addr),
		.entry_frame(entry_frame),
		.entry_flags(entry_flags),
		.lookup(lookup),
		.tlb_wr(tlb_wr),
		.tlb_wr_frame(tlb_wr_frame),
		.tlb_wr_flags(tlb_wr_flags)
	);

	// Lookup runs on the incoming request and fill on the latched one
	mmu_tlb tlb_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(iTLB_FLUSH),
		.iMEMORY_LOCK(iMEMORY_LOCK),
		.lookup(lookup),
		.lookup_asid(iLOGIC.asid),
		.lookup_vpn(iLOGIC.addr[`MMU_ADDR_W-1:`MMU_PAGE_SHIFT]),
		.wr(tlb_wr),
		.wr_asid(req.asid),
		.wr_vpn(req.addr[`MMU_ADDR_W-1:`MMU_PAGE_SHIFT]),
		.wr_frame(tlb_wr_frame),
		.wr_flags(tlb_wr_flags),
		.valid(tlb_valid),
		.hit(tlb_hit),
		.frame(tlb_frame),
		.flags(tlb_flags)
	);

	mmu_mem_mux mem_mux_inst (
		.req_valid(req_valid),
		.req(req),
		.state(state),
		.iMEMORY_LOCK(iMEMORY_LOCK),
		.tlb_valid(tlb_valid),
		.tlb_hit(tlb_hit),
		.tlb_frame(tlb_frame),
		.tlb_flags(tlb_flags),
		.table_addr(table_addr),
		.entry_frame(entry_frame),
		.entry_flags(entry_flags),
		.oMEMORY(oMEMORY),
		.oMMUFLAGS_REQ(oMMUFLAGS_REQ),
		.oMMUFLAGS_FLAGS(oMMUFLAGS_FLAGS)
	);

endmodule

//--- hdl/mmu_walk_ctrl.sv
`timescale 1ns/1ns
`include "mmu_defines.svh"

module mmu_walk_ctrl (
	input logic iCLOCK,
	input logic inRESET,
	input logic iLOGIC_REQ,
	input mmu_pkg::logic_req_t iLOGIC,
	input logic iMEMORY_LOCK,
	input logic iMEMORY_VALID,
	input mmu_pkg::mem_rdata_t iMEMORY_DATA,
	input logic tlb_valid,
	input logic tlb_hit,
	output logic oLOGIC_LOCK,
	output logic req_valid,
	output mmu_pkg::logic_req_t req,
	output mmu_pkg::walk_state_e state,
	output mmu_pkg::paddr_t table_addr,
	output mmu_pkg::frame_t entry_frame,
	output mmu_pkg::mmu_flags_t entry_flags,
	output logic lookup,
	output logic tlb_wr,
	output mmu_pkg::frame_t tlb_wr_frame,
	output mmu_pkg::mmu_flags_t tlb_wr_flags
);

	localparam int VPN_W = `MMU_ADDR_W - `MMU_PAGE_SHIFT;
	// Two-level walk splits the page number in halves
	localparam int L2_IDX_W = VPN_W / 2;

	logic paging;
	logic idle_cmd;
	logic idle_miss;
	logic accept;
	logic cmd_taken;
	logic wait_valid;
	mmu_pkg::vpn_t vpn;
	mmu_pkg::paddr_t l1_index;
	mmu_pkg::paddr_t l2_index_hi;
	mmu_pkg::paddr_t l2_index_lo;
	mmu_pkg::frame_t resp_frame;
	mmu_pkg::mmu_flags_t resp_flags;

	assign paging = req.mode != mmu_pkg::PAGING_OFF;

	// Idle with a pass-through or hit command ready
	assign idle_cmd = state == mmu_pkg::WALK_IDLE && req_valid &&
		(!paging || (tlb_valid && tlb_hit));
	// Idle on the TLB answer that starts a walk
	assign idle_miss = state == mmu_pkg::WALK_IDLE && req_valid && paging &&
		tlb_valid && !tlb_hit;

	// The miss cycle also locks so the latch survives into the walk
	assign oLOGIC_LOCK = state != mmu_pkg::WALK_IDLE || idle_miss ||
		(idle_cmd && iMEMORY_LOCK);
	assign accept = iLOGIC_REQ && !oLOGIC_LOCK;
	assign lookup = accept;

	// Final command of this request leaves the port
	assign cmd_taken = !iMEMORY_LOCK && (idle_cmd || state == mmu_pkg::WALK_ACCESS);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			req_valid <= 1'b0;
		end else if (accept) begin
			req_valid <= 1'b1;
		end else if (cmd_taken) begin
			req_valid <= 1'b0;
		end
	end

	// Request payload
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			req <= iLOGIC;
		end
	end

	// Walk FSM
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= mmu_pkg::WALK_IDLE;
		end else begin
			case (state)
				mmu_pkg::WALK_IDLE: begin
					if (idle_miss) begin
						state <= mmu_pkg::WALK_T1_REQ;
					end
				end
				mmu_pkg::WALK_T1_REQ: begin
					if (!iMEMORY_LOCK) begin
						state <= mmu_pkg::WALK_T1_WAIT;
					end
				end
				mmu_pkg::WALK_T1_WAIT: begin
					if (iMEMORY_VALID) begin
						// Level two needs the second table
						if (req.mode == mmu_pkg::PAGING_L2) begin
							state <= mmu_pkg::WALK_T2_REQ;
						end else begin
							state <= mmu_pkg::WALK_ACCESS;
						end
					end
				end
				mmu_pkg::WALK_T2_REQ: begin
					if (!iMEMORY_LOCK) begin
						state <= mmu_pkg::WALK_T2_WAIT;
					end
				end
				mmu_pkg::WALK_T2_WAIT: begin
					if (iMEMORY_VALID) begin
						state <= mmu_pkg::WALK_ACCESS;
					end
				end
				mmu_pkg::WALK_ACCESS: begin
					if (!iMEMORY_LOCK) begin
						state <= mmu_pkg::WALK_IDLE;
					end
				end
				default: begin
					state <= mmu_pkg::WALK_IDLE;
				end
			endcase
		end
	end

	// Entry index scaled by the 8-byte entry size
	assign vpn = req.addr[`MMU_ADDR_W-1:`MMU_PAGE_SHIFT];
	assign l1_index = mmu_pkg::paddr_t'({vpn, {`MMU_ENTRY_SHIFT{1'b0}}});
	assign l2_index_hi = mmu_pkg::paddr_t'({vpn[VPN_W-1:L2_IDX_W], {`MMU_ENTRY_SHIFT{1'b0}}});
	assign l2_index_lo = mmu_pkg::paddr_t'({vpn[L2_IDX_W-1:0], {`MMU_ENTRY_SHIFT{1'b0}}});

	always_comb begin
		case (state)
			mmu_pkg::WALK_T1_REQ: begin
				if (req.mode == mmu_pkg::PAGING_L1) begin
					table_addr = req.pdt + l1_index;
				end else begin
					table_addr = req.pdt + l2_index_hi;
				end
			end
			// Second table base comes from the first entry
			mmu_pkg::WALK_T2_REQ: table_addr = {entry_frame, {`MMU_PAGE_SHIFT{1'b0}}} + l2_index_lo;
			default: table_addr = '0;
		endcase
	end

	// Returned entry split into base or frame and flags
	assign resp_frame = iMEMORY_DATA[`MMU_ADDR_W-1:`MMU_PAGE_SHIFT];
	assign resp_flags = iMEMORY_DATA[`MMU_FLAGS_W-1:0];
	assign wait_valid = iMEMORY_VALID &&
		(state == mmu_pkg::WALK_T1_WAIT || state == mmu_pkg::WALK_T2_WAIT);

	always_ff @(posedge iCLOCK) begin
		if (wait_valid) begin
			entry_frame <= resp_frame;
			entry_flags <= resp_flags;
		end
	end

	// Last table response fills the TLB
	assign tlb_wr = iMEMORY_VALID &&
		((state == mmu_pkg::WALK_T1_WAIT && req.mode == mmu_pkg::PAGING_L1) ||
		state == mmu_pkg::WALK_T2_WAIT);
	assign tlb_wr_frame = resp_frame;
	assign tlb_wr_flags = resp_flags;

	// Latch moves only in idle so every walk runs in a paging mode
	a_off_stays_idle: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		state != mmu_pkg::WALK_IDLE |-> paging);

endmodule

//--- tlb/mmu_tlb.sv
`timescale 1ns/1ns
`include "mmu_defines.svh"

module mmu_tlb (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic iMEMORY_LOCK,
	input logic lookup,
	input mmu_pkg::asid_t lookup_asid,
	input mmu_pkg::vpn_t lookup_vpn,
	input logic wr,
	input mmu_pkg::asid_t wr_asid,
	input mmu_pkg::vpn_t wr_vpn,
	input mmu_pkg::frame_t wr_frame,
	input mmu_pkg::mmu_flags_t wr_flags,
	output logic valid,
	output logic hit,
	output mmu_pkg::frame_t frame,
	output mmu_pkg::mmu_flags_t flags
);

	localparam int PTR_W = $clog2(`MMU_TLB_ENTRIES);

	logic [`MMU_TLB_ENTRIES-1:0] ent_valid;
	logic [`MMU_TLB_ENTRIES-1:0] match;
	mmu_pkg::asid_t ent_asid [`MMU_TLB_ENTRIES];
	mmu_pkg::vpn_t ent_vpn [`MMU_TLB_ENTRIES];
	mmu_pkg::frame_t ent_frame [`MMU_TLB_ENTRIES];
	mmu_pkg::mmu_flags_t ent_flags [`MMU_TLB_ENTRIES];
	logic [PTR_W-1:0] fill_ptr;
	mmu_pkg::frame_t match_frame;
	mmu_pkg::mmu_flags_t match_flags;

	// Parallel compare over all entries
	always_comb begin
		match_frame = '0;
		match_flags = '0;
		for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
			match[i] = ent_valid[i] && ent_asid[i] == lookup_asid && ent_vpn[i] == lookup_vpn;
			// At most one match so the OR acts as a mux
			if (match[i]) begin
				match_frame = match_frame | ent_frame[i];
				match_flags = match_flags | ent_flags[i];
			end
		end
	end

	// Valid bits and round-robin victim
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ent_valid <= '0;
			fill_ptr <= '0;
		end else if (flush) begin
			ent_valid <= '0;
		end else if (wr) begin
			ent_valid[fill_ptr] <= 1'b1;
			fill_ptr <= fill_ptr + 1'b1;
		end
	end

	// Entry contents
	always_ff @(posedge iCLOCK) begin
		if (wr) begin
			ent_asid[fill_ptr] <= wr_asid;
			ent_vpn[fill_ptr] <= wr_vpn;
			ent_frame[fill_ptr] <= wr_frame;
			ent_flags[fill_ptr] <= wr_flags;
		end
	end

	// Registered answer held while the memory port is locked
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid <= 1'b0;
			hit <= 1'b0;
		end else if (lookup) begin
			valid <= 1'b1;
			hit <= |match;
		end else if (!iMEMORY_LOCK) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (lookup) begin
			frame <= match_frame;
			flags <= match_flags;
		end
	end

	// Fill never duplicates a live page
	a_single_match: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		lookup |-> $onehot0(match));

	// Flush only between walks
	a_no_wr_on_flush: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		wr |-> !flush);

endmodule
